//--- hw/apb_job_port.sv
`default_nettype none

module apb_job_port
	import fp_format_pkg::*;
	import norm_regmap_pkg::*;
(
	input logic clk_i,
	input logic rst_i,
	input logic psel_i,
	input logic penable_i,
	input logic pwrite_i,
	input logic [APB_AW-1:0] paddr_i,
	input logic [APB_DW-1:0] pwdata_i,
	output logic [APB_DW-1:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o,
	input logic fifo_full_i,
	norm_job_if.source job,
	norm_result_if.sink res
);

	localparam int ZERO_BIT = 29;
	localparam int UFLOW_BIT = 30;
	localparam int SIGN_BIT = 31;

	mant_t mant_q;
	exp_t exp_q;
	logic sign_q;
	logic drop_q;

	reg_addr_e addr;
	logic access;
	logic wr_access;
	logic rd_access;
	logic mapped;
	logic push_req;
	logic push_drop;
	logic [APB_DW-1:0] rdata;

	assign addr = reg_addr_e'(paddr_i);
	assign access = psel_i && penable_i;
	assign wr_access = access && pwrite_i;
	assign rd_access = access && !pwrite_i;

	// The push is decided in the access phase, so valid never waits on ready.
	assign push_req = wr_access && (addr == CMD) && pwdata_i[0];
	assign push_drop = push_req && fifo_full_i;
	assign job.valid = push_req && !fifo_full_i;
	assign job.data = '{sign: sign_q, exp: exp_q, mant: mant_q};

	assign res.consume = rd_access && (addr == RES_EXP) && res.valid;

	// No wait states.
	assign pready_o = 1'b1;
	assign pslverr_o = access && (!mapped || push_drop);
	assign prdata_o = rdata;

	always_comb begin
		rdata = '0;
		mapped = 1'b1;
		case (addr)
			MANT_LO: rdata = mant_q[APB_DW-1:0];
			MANT_HI: rdata[MANT_W-APB_DW-1:0] = mant_q[MANT_W-1:APB_DW];
			EXP_SIGN: begin
				rdata[EXP_W-1:0] = exp_q;
				rdata[SIGN_BIT] = sign_q;
			end
			CMD: rdata = '0;
			STATUS: begin
				rdata[STAT_FULL_BIT] = fifo_full_i;
				rdata[STAT_RES_BIT] = res.valid;
				rdata[STAT_DROP_BIT] = drop_q;
			end
			RES_LO: rdata = res.mant[APB_DW-1:0];
			RES_HI: rdata[MANT_W-APB_DW-1:0] = res.mant[MANT_W-1:APB_DW];
			RES_EXP: begin
				rdata[EXP_W-1:0] = res.exp;
				rdata[ZERO_BIT] = res.zero;
				rdata[UFLOW_BIT] = res.underflow;
				rdata[SIGN_BIT] = res.sign;
			end
			default: mapped = 1'b0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			mant_q <= '0;
			exp_q <= '0;
			sign_q <= 1'b0;
			drop_q <= 1'b0;
		end else if (wr_access) begin
			case (addr)
				MANT_LO: mant_q[APB_DW-1:0] <= pwdata_i;
				MANT_HI: mant_q[MANT_W-1:APB_DW] <= pwdata_i[MANT_W-APB_DW-1:0];
				EXP_SIGN: begin
					exp_q <= pwdata_i[EXP_W-1:0];
					sign_q <= pwdata_i[SIGN_BIT];
				end
				CMD: begin
					if (push_drop) begin
						drop_q <= 1'b1;
					end
				end
				STATUS: begin
					if (pwdata_i[STAT_DROP_BIT]) begin
						drop_q <= 1'b0;
					end
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/fp_format_pkg.sv
`default_nettype none

package fp_format_pkg;

	// Un-normalized result of the double-precision adder.
	// The mantissa keeps the carry position at its top bit.
	localparam int MANT_W = 55;
	localparam int EXP_W = 11;
	localparam int LZC_W = 6;

	typedef logic [MANT_W-1:0] mant_t;
	typedef logic [EXP_W-1:0] exp_t;
	typedef logic [LZC_W-1:0] lzc_t;

	typedef struct packed {
		logic sign;
		exp_t exp;
		mant_t mant;
	} norm_job_t;

	// The exponent cannot go below zero.
	// A larger leading-zero count means the result is denormal.
	function automatic logic norm_underflow(lzc_t count, exp_t exp);
		return exp_t'(count) > exp;
	endfunction

	// The shift is limited by the exponent on underflow.
	// In that case the exponent is below the count, so it fits the count width.
	function automatic lzc_t norm_shift(lzc_t count, exp_t exp);
		if (norm_underflow(count, exp)) begin
			return exp[LZC_W-1:0];
		end
		return count;
	endfunction

endpackage

`default_nettype wire

//--- hw/fp_norm_top.sv
`default_nettype none

module fp_norm_top import norm_regmap_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input logic clk_i,
	input logic rst_i,
	input logic psel_i,
	input logic penable_i,
	input logic pwrite_i,
	input logic [APB_AW-1:0] paddr_i,
	input logic [APB_DW-1:0] pwdata_i,
	output logic [APB_DW-1:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o
);

	logic fifo_full;

	norm_job_if push_if ();
	norm_job_if pop_if ();
	norm_result_if res_if ();

	apb_job_port u_apb (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.psel_i      (psel_i),
		.penable_i   (penable_i),
		.pwrite_i    (pwrite_i),
		.paddr_i     (paddr_i),
		.pwdata_i    (pwdata_i),
		.prdata_o    (prdata_o),
		.pready_o    (pready_o),
		.pslverr_o   (pslverr_o),
		.fifo_full_i (fifo_full),
		.job         (push_if.source),
		.res         (res_if.sink)
	);

	job_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_fifo (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.wr     (push_if.sink),
		.rd     (pop_if.source),
		.full_o (fifo_full)
	);

	normalizer u_norm (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.job   (pop_if.sink),
		.res   (res_if.source)
	);

endmodule

`default_nettype wire

//--- hw/job_fifo.sv
`default_nettype none

module job_fifo import fp_format_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input logic clk_i,
	input logic rst_i,
	norm_job_if.sink wr,
	norm_job_if.source rd,
	output logic full_o
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	norm_job_t mem [FIFO_DEPTH];

	// The extra top bit tells a full buffer from an empty one.
	logic [PTR_W:0] wr_ptr_q;
	logic [PTR_W:0] rd_ptr_q;
	logic [PTR_W:0] wr_ptr_d;
	logic [PTR_W:0] rd_ptr_d;
	logic push;
	logic pop;
	logic valid_q;

	assign full_o = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]) &&
		(wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);

	assign wr.ready = !full_o;
	assign push = wr.valid && wr.ready;
	assign pop = rd.valid && rd.ready;

	assign wr_ptr_d = wr_ptr_q + (PTR_W+1)'(push);
	assign rd_ptr_d = rd_ptr_q + (PTR_W+1)'(pop);

	// A written entry shows up on the read side one cycle after the push.
	assign rd.valid = valid_q;
	assign rd.data = mem[rd_ptr_q[PTR_W-1:0]];

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			valid_q <= 1'b0;
		end else begin
			wr_ptr_q <= wr_ptr_d;
			rd_ptr_q <= rd_ptr_d;
			valid_q <= (wr_ptr_d != rd_ptr_d);
		end
	end

	always_ff @(posedge clk_i) begin
		if (push) begin
			mem[wr_ptr_q[PTR_W-1:0]] <= wr.data;
		end
	end

endmodule

`default_nettype wire

//--- hw/norm_if.sv
`default_nettype none

// A job transfer happens when valid and ready are both high.
interface norm_job_if import fp_format_pkg::*; ();
	logic valid;
	logic ready;
	norm_job_t data;

	modport source (output valid, output data, input ready);
	modport sink (input valid, input data, output ready);
endinterface

// Normalized result held until software reads RES_EXP.
interface norm_result_if import fp_format_pkg::*; ();
	logic valid;
	logic sign;
	exp_t exp;
	mant_t mant;
	logic zero;
	logic underflow;
	logic consume;

	modport source (
		output valid, output sign, output exp, output mant,
		output zero, output underflow, input consume
	);
	modport sink (
		input valid, input sign, input exp, input mant,
		input zero, input underflow, output consume
	);
endinterface

`default_nettype wire

//--- hw/norm_regmap_pkg.sv
`default_nettype none

package norm_regmap_pkg;

	localparam int APB_AW = 8;
	localparam int APB_DW = 32;

	// Register offsets of the APB job port.
	typedef enum logic [APB_AW-1:0] {
		MANT_LO  = 8'h00,
		MANT_HI  = 8'h04,
		EXP_SIGN = 8'h08,
		CMD      = 8'h0C,
		STATUS   = 8'h10,
		RES_LO   = 8'h14,
		RES_HI   = 8'h18,
		RES_EXP  = 8'h1C
	} reg_addr_e;

	// Bit positions in STATUS.
	localparam int STAT_FULL_BIT = 0;
	localparam int STAT_RES_BIT = 1;
	// This sticky flag is cleared by writing a one to its bit.
	localparam int STAT_DROP_BIT = 2;

endpackage

`default_nettype wire

//--- hw/normalizer.sv
`default_nettype none

module normalizer import fp_format_pkg::*; (
	input logic clk_i,
	input logic rst_i,
	norm_job_if.sink job,
	norm_result_if.source res
);

	lzc_t lzc;
	lzc_t shift;
	logic mant_zero;
	logic uflow;
	logic pop;

	logic valid_q;
	logic sign_q;
	exp_t exp_q;
	mant_t mant_q;
	logic zero_q;
	logic uflow_q;

	priority_codec_55 u_codec (
		.data_i  (job.data.mant),
		.count_o (lzc),
		.zero_o  (mant_zero)
	);

	assign uflow = norm_underflow(lzc, job.data.exp);
	assign shift = norm_shift(lzc, job.data.exp);

	// A consumed result frees the holding register in the same cycle.
	assign job.ready = !valid_q || res.consume;
	assign pop = job.valid && job.ready;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			valid_q <= 1'b0;
		end else if (pop) begin
			valid_q <= 1'b1;
		end else if (res.consume) begin
			valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (pop) begin
			sign_q <= job.data.sign;
			if (mant_zero) begin
				mant_q <= '0;
				exp_q <= '0;
				zero_q <= 1'b1;
				uflow_q <= 1'b0;
			end else begin
				mant_q <= job.data.mant << shift;
				exp_q <= job.data.exp - exp_t'(shift);
				zero_q <= 1'b0;
				uflow_q <= uflow;
			end
		end
	end

	assign res.valid = valid_q;
	assign res.sign = sign_q;
	assign res.exp = exp_q;
	assign res.mant = mant_q;
	assign res.zero = zero_q;
	assign res.underflow = uflow_q;

endmodule

`default_nettype wire

//--- hw/priority_codec_55.sv
`default_nettype none

module priority_codec_55 import fp_format_pkg::*; (
	input mant_t data_i,
	output lzc_t count_o,
	output logic zero_o
);

	logic found;

	// Search from the carry position down.
	// The first one seen sets the count, lower bits are ignored.
	always_comb begin
		found = 1'b0;
		count_o = '0;
		for (int i = MANT_W - 1; i >= 0; i--) begin
			if (!found && data_i[i]) begin
				found = 1'b1;
				count_o = lzc_t'(MANT_W - 1 - i);
			end
		end
	end

	// An all-zero input leaves the count at zero.
	assign zero_o = !found;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then check the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module fp_norm_tb \
	--Mdir build -o fp_norm_sim

./build/fp_norm_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "all tests passed" sim.log; then
	exit 0
fi
exit 1

//--- tb.f
hw/fp_format_pkg.sv
hw/norm_regmap_pkg.sv
hw/norm_if.sv
hw/priority_codec_55.sv
hw/job_fifo.sv
hw/normalizer.sv
hw/apb_job_port.sv
hw/fp_norm_top.sv
verification/fp_norm_tb.sv

//--- verification/fp_norm_tb.sv
`default_nettype none

module fp_norm_tb
	import fp_format_pkg::*;
	import norm_regmap_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 5;
	localparam int RANDOM_JOBS = 20;
	localparam int POLL_LIMIT = 20;
	// A job needs about 30 bus cycles. The limit allows 100 for each of 40 jobs.
	localparam int TIMEOUT_CYCLES = 40 * 100;
	localparam int RES_ZERO_BIT = 29;
	localparam int RES_UFLOW_BIT = 30;
	localparam int RES_SIGN_BIT = 31;

	logic clk_i;
	logic rst_i;
	logic psel_i;
	logic penable_i;
	logic pwrite_i;
	logic [APB_AW-1:0] paddr_i;
	logic [APB_DW-1:0] pwdata_i;
	logic [APB_DW-1:0] prdata_o;
	logic pready_o;
	logic pslverr_o;

	integer seed = 32'hfe49_c9e4;
	int cycles;

	fp_norm_top uut (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.psel_i    (psel_i),
		.penable_i (penable_i),
		.pwrite_i  (pwrite_i),
		.paddr_i   (paddr_i),
		.pwdata_i  (pwdata_i),
		.prdata_o  (prdata_o),
		.pready_o  (pready_o),
		.pslverr_o (pslverr_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk_i);
			cycles++;
		end
		$display("Simulation stopped after %0d cycles without finishing.", cycles);
		$display("tests failed");
		$fatal(1);
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check_mant(input string name, input mant_t want, input mant_t got);
		if (got !== want) begin
			report_failure($sformatf("FAILED at %0t: %s expected 0x%h, got 0x%h",
				$time, name, want, got));
		end
	endtask

	task automatic check_exp(input string name, input exp_t want, input exp_t got);
		if (got !== want) begin
			report_failure($sformatf("FAILED at %0t: %s expected %0d, got %0d",
				$time, name, want, got));
		end
	endtask

	task automatic check_bit(input string name, input logic want, input logic got);
		if (got !== want) begin
			report_failure($sformatf("FAILED at %0t: %s expected %b, got %b",
				$time, name, want, got));
		end
	endtask

	task automatic check_err(input string name, input logic want, input logic got);
		if (got !== want) begin
			report_failure($sformatf("FAILED at %0t: pslverr_o on %s expected %b, got %b",
				$time, name, want, got));
		end
	endtask

	task automatic check_word(input string name, input logic [APB_DW-1:0] want,
			input logic [APB_DW-1:0] got);
		if (got !== want) begin
			report_failure($sformatf("FAILED at %0t: %s expected 0x%h, got 0x%h",
				$time, name, want, got));
		end
	endtask

	// Setup and access phase, then back to idle.
	task automatic apb_access(input logic write, input logic [APB_AW-1:0] addr,
			input logic [APB_DW-1:0] wdata, output logic [APB_DW-1:0] rdata,
			output logic err);
		@(negedge clk_i);
		psel_i = 1'b1;
		penable_i = 1'b0;
		pwrite_i = write;
		paddr_i = addr;
		pwdata_i = wdata;
		@(negedge clk_i);
		penable_i = 1'b1;
		#(CLK_PERIOD / 4);
		check_bit("pready_o", 1'b1, pready_o);
		rdata = prdata_o;
		err = pslverr_o;
		@(negedge clk_i);
		psel_i = 1'b0;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
	endtask

	task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
			output logic err);
		logic [APB_DW-1:0] unused;
		apb_access(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
			output logic err);
		apb_access(1'b0, addr, '0, data, err);
	endtask

	// The expected result counts leading zeros bit by bit from the carry position down.
	task automatic ref_normalize(input norm_job_t job, output mant_t mant,
			output exp_t exponent, output logic zero, output logic uflow);
		int lead;
		int shift;
		zero = (job.mant == '0);
		uflow = 1'b0;
		mant = '0;
		exponent = '0;
		if (!zero) begin
			lead = 0;
			while (!job.mant[MANT_W-1-lead]) begin
				lead++;
			end
			if (lead > int'(job.exp)) begin
				shift = int'(job.exp);
				uflow = 1'b1;
			end else begin
				shift = lead;
				exponent = job.exp - exp_t'(lead);
			end
			mant = job.mant << shift;
		end
	endtask

	function automatic norm_job_t build_job(input logic sign, input exp_t e, input mant_t m);
		return '{sign: sign, exp: e, mant: m};
	endfunction

	// Random shifts spread the leading one, and small exponents provoke underflow.
	task automatic make_random_job(output norm_job_t job);
		logic [63:0] raw;
		int sh;
		raw = {$random(seed), $random(seed)};
		sh = {$random(seed)} % 56;
		job.sign = raw[63];
		job.mant = mant_t'(raw) >> sh;
		if ({$random(seed)} % 4 == 0) begin
			job.exp = exp_t'({$random(seed)} % 64);
		end else begin
			job.exp = exp_t'($random(seed));
		end
	endtask

	task automatic push_job(input norm_job_t job, output logic err);
		logic wr_err;
		apb_write(MANT_LO, job.mant[APB_DW-1:0], wr_err);
		check_err("MANT_LO write", 1'b0, wr_err);
		apb_write(MANT_HI, APB_DW'(job.mant[MANT_W-1:APB_DW]), wr_err);
		check_err("MANT_HI write", 1'b0, wr_err);
		apb_write(EXP_SIGN, {job.sign, 20'b0, job.exp}, wr_err);
		check_err("EXP_SIGN write", 1'b0, wr_err);
		apb_write(CMD, 32'h1, err);
	endtask

	task automatic wait_result();
		logic [APB_DW-1:0] status;
		logic err;
		int polls;
		status = '0;
		polls = 0;
		while (!status[STAT_RES_BIT] && polls < POLL_LIMIT) begin
			apb_read(STATUS, status, err);
			check_err("STATUS read", 1'b0, err);
			polls++;
		end
		if (!status[STAT_RES_BIT]) begin
			report_failure("The result valid bit in STATUS never rose after a push.");
		end
	endtask

	task automatic check_result(input norm_job_t job);
		mant_t want_mant;
		exp_t want_exp;
		logic want_zero;
		logic want_uflow;
		logic [APB_DW-1:0] lo;
		logic [APB_DW-1:0] hi;
		logic [APB_DW-1:0] ex;
		logic err;
		ref_normalize(job, want_mant, want_exp, want_zero, want_uflow);
		wait_result();
		apb_read(RES_LO, lo, err);
		check_err("RES_LO read", 1'b0, err);
		apb_read(RES_HI, hi, err);
		check_err("RES_HI read", 1'b0, err);
		apb_read(RES_EXP, ex, err);
		check_err("RES_EXP read", 1'b0, err);
		check_mant("result mantissa", want_mant, {hi[MANT_W-APB_DW-1:0], lo});
		check_exp("result exponent", want_exp, ex[EXP_W-1:0]);
		check_bit("result zero flag", want_zero, ex[RES_ZERO_BIT]);
		check_bit("result underflow flag", want_uflow, ex[RES_UFLOW_BIT]);
		check_bit("result sign", job.sign, ex[RES_SIGN_BIT]);
	endtask

	task automatic run_job(input norm_job_t job);
		logic err;
		push_job(job, err);
		check_err("CMD push", 1'b0, err);
		check_result(job);
	endtask

	task automatic reset_defaults();
		logic [APB_DW-1:0] data;
		logic err;
		apb_read(STATUS, data, err);
		check_err("STATUS read", 1'b0, err);
		check_word("STATUS after reset", '0, data);
		apb_read(8'h20, data, err);
		check_err("unmapped read", 1'b1, err);
	endtask

	task automatic directed_shifts();
		run_job(build_job(1'b0, 11'd1023, mant_t'(1) << 54));
		run_job(build_job(1'b1, 11'd1000, mant_t'(1)));
		run_job(build_job(1'b0, 11'd500, (mant_t'(1) << 25) | mant_t'(55'h1234)));
	endtask

	task automatic zero_and_underflow();
		run_job(build_job(1'b1, 11'd700, '0));
		run_job(build_job(1'b0, 11'd20, mant_t'(1) << 10));
	endtask

	task automatic back_pressure();
		norm_job_t sent[$];
		norm_job_t job;
		logic [APB_DW-1:0] status;
		logic err;
		int depth;
		depth = uut.FIFO_DEPTH;
		for (int i = 0; i < depth + 2; i++) begin
			make_random_job(job);
			push_job(job, err);
			if (i < depth + 1) begin
				check_err("accepted CMD push", 1'b0, err);
				sent.push_back(job);
			end else begin
				check_err("refused CMD push", 1'b1, err);
			end
		end
		apb_read(STATUS, status, err);
		check_bit("STATUS full bit", 1'b1, status[STAT_FULL_BIT]);
		check_bit("STATUS drop bit", 1'b1, status[STAT_DROP_BIT]);
		apb_write(STATUS, 32'h1 << STAT_DROP_BIT, err);
		check_err("STATUS write", 1'b0, err);
		apb_read(STATUS, status, err);
		check_bit("STATUS drop bit after clear", 1'b0, status[STAT_DROP_BIT]);
		while (sent.size() > 0) begin
			check_result(sent.pop_front());
		end
		apb_read(STATUS, status, err);
		check_word("STATUS after draining", '0, status);
	endtask

	task automatic random_jobs();
		norm_job_t job;
		for (int i = 0; i < RANDOM_JOBS; i++) begin
			make_random_job(job);
			run_job(job);
		end
	endtask

	initial begin
		rst_i = 1'b1;
		psel_i = 1'b0;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
		paddr_i = '0;
		pwdata_i = '0;
		repeat (RESET_CYCLES) @(posedge clk_i);
		@(negedge clk_i);
		rst_i = 1'b0;
		reset_defaults();
		directed_shifts();
		zero_and_underflow();
		back_pressure();
		random_jobs();
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire
